// File: mcu_link_pkg.sv
// NCU-MCU link sizes, per-direction command codes and the first-beat decode type for the monitor
package mcu_link_pkg;

    // One beat per valid cycle, 32 beats per packet
    localparam int BEAT_W        = 4;
    localparam int PKT_W         = 128;
    localparam int BEATS_PER_PKT = 32;

    // Counts 0 to 32, so one bit more than the beat index
    localparam int BEAT_CNT_W    = 6;

    // Downstream commands, NCU to MCU
    typedef enum logic [BEAT_W-1:0] {
        REQ_READ  = 4'b0100,
        REQ_WRITE = 4'b0101,
        REQ_IFILL = 4'b0110
    } req_op_e;

    // Upstream commands, MCU to NCU
    typedef enum logic [BEAT_W-1:0] {
        RSP_READ_NACK  = 4'b0000,
        RSP_READ_ACK   = 4'b0001,
        RSP_IFILL_ACK  = 4'b0011,
        RSP_IFILL_NACK = 4'b0111,
        RSP_INT        = 4'b1000,
        RSP_INT_VEC    = 4'b1100
    } rsp_op_e;

    // The same first beat read as a request on a downstream lane
    // or as a response on an upstream lane
    typedef union packed {
        req_op_e req;
        rsp_op_e rsp;
    } first_beat_u;

endpackage

// File: mon_csr_pkg.sv
// Wishbone widths and register map of the link monitor, shared by the lanes and the CSR block
package mon_csr_pkg;

    localparam int WB_DAT_W   = 32;
    localparam int WB_ADR_W   = 7;

    // Word address is {lane, register}
    localparam int LANE_SEL_W = 4;
    localparam int REG_SEL_W  = 3;

    // Statistics counters wrap at this width
    localparam int CNT_W      = 16;

    // Per-lane registers, packet words least significant first
    localparam logic [REG_SEL_W-1:0] REG_PKT0      = 3'd0;
    localparam logic [REG_SEL_W-1:0] REG_PKT1      = 3'd1;
    localparam logic [REG_SEL_W-1:0] REG_PKT2      = 3'd2;
    localparam logic [REG_SEL_W-1:0] REG_PKT3      = 3'd3;
    localparam logic [REG_SEL_W-1:0] REG_INFO      = 3'd4;
    localparam logic [REG_SEL_W-1:0] REG_PKT_CNT   = 3'd5;
    localparam logic [REG_SEL_W-1:0] REG_ABORT_CNT = 3'd6;
    localparam logic [REG_SEL_W-1:0] REG_STALL_CNT = 3'd7;

    // Info word fields above the raw first beat in bits 3:0
    localparam int INFO_REC_BIT  = 4;
    localparam int INFO_CAPT_BIT = 8;

    // This lane value addresses the control block instead of a lane
    localparam logic [LANE_SEL_W-1:0] CTRL_LANE = 4'd15;
    localparam logic [REG_SEL_W-1:0]  REG_CTRL  = 3'd0;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_CLEAR_BIT  = 1;

endpackage

// File: nibble_packet_assembler.sv
// Builds 128-bit packets from the nibble beats of one link lane and classifies the first beat
`timescale 1ns/100ps

module nibble_packet_assembler
    import mcu_link_pkg::*;
#(
    parameter bit UPSTREAM = 1'b0
)
(
    input  logic              iol2clk,
    input  logic              rst,
    input  logic              enable,
    input  logic              vld,
    input  logic              stall,
    input  logic [BEAT_W-1:0] data,
    output logic              pkt_done,
    output logic              pkt_abort,
    output logic [PKT_W-1:0]  pkt,
    output logic [BEAT_W-1:0] first_beat,
    output logic              recognized
);

    localparam logic [BEAT_CNT_W-1:0] FULL_CNT = BEAT_CNT_W'(BEATS_PER_PKT);

    logic [BEAT_CNT_W-1:0] beat_cnt;
    logic [BEAT_CNT_W-2:0] beat_pos;
    logic [PKT_W-1:0]      pkt_q;
    logic                  take_beat;
    first_beat_u           fb;

    // Beats past the 32nd are dropped while valid stays high
    assign take_beat = enable && vld && !stall && (beat_cnt < FULL_CNT);
    assign beat_pos  = beat_cnt[BEAT_CNT_W-2:0];

    always_ff @(posedge iol2clk)
    begin
        if (rst)
        begin
            beat_cnt  <= '0;
            pkt_done  <= 1'b0;
            pkt_abort <= 1'b0;
        end
        else if (!enable)
        begin
            // A packet in flight is lost silently when the monitor is turned off
            beat_cnt  <= '0;
            pkt_done  <= 1'b0;
            pkt_abort <= 1'b0;
        end
        else
        begin
            pkt_done  <= !vld && (beat_cnt == FULL_CNT);
            pkt_abort <= !vld && (beat_cnt != '0) && (beat_cnt != FULL_CNT);
            if (!vld)
                beat_cnt <= '0;
            else if (take_beat)
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // Beat n lands at bits 4n+3:4n
    always_ff @(posedge iol2clk)
    begin
        if (take_beat)
            pkt_q[beat_pos*BEAT_W +: BEAT_W] <= data;
    end

    assign pkt        = pkt_q;
    assign fb         = pkt_q[BEAT_W-1:0];
    assign first_beat = fb;

    always_comb
    begin
        if (UPSTREAM)
        begin
            case (fb.rsp)
                RSP_READ_NACK, RSP_READ_ACK, RSP_IFILL_ACK,
                RSP_IFILL_NACK, RSP_INT, RSP_INT_VEC:
                    recognized = 1'b1;
                default:
                    recognized = 1'b0;
            endcase
        end
        else
        begin
            case (fb.req)
                REQ_READ, REQ_WRITE, REQ_IFILL:
                    recognized = 1'b1;
                default:
                    recognized = 1'b0;
            endcase
        end
    end

endmodule

// File: lane_stats.sv
// Keeps the last completed packet of one lane and its packet, abort and stall-onset counters
`timescale 1ns/100ps

module lane_stats
    import mcu_link_pkg::*;
    import mon_csr_pkg::*;
(
    input  logic                iol2clk,
    input  logic                rst,
    input  logic                enable,
    input  logic                clear,
    input  logic                stall,
    input  logic                pkt_done,
    input  logic                pkt_abort,
    input  logic [PKT_W-1:0]    pkt,
    input  logic [BEAT_W-1:0]   first_beat,
    input  logic                recognized,
    output logic [PKT_W-1:0]    last_pkt,
    output logic [WB_DAT_W-1:0] last_info,
    output logic [CNT_W-1:0]    pkt_cnt,
    output logic [CNT_W-1:0]    abort_cnt,
    output logic [CNT_W-1:0]    stall_cnt
);

    logic              stall_q;
    logic              captured;
    logic [PKT_W-1:0]  pkt_q;
    logic [BEAT_W-1:0] beat_q;
    logic              rec_q;

    // Tracked even while disabled, so re-enabling inside a stall is not an onset
    always_ff @(posedge iol2clk)
    begin
        if (rst)
            stall_q <= 1'b0;
        else
            stall_q <= stall;
    end

    always_ff @(posedge iol2clk)
    begin
        if (rst || clear)
        begin
            captured  <= 1'b0;
            pkt_cnt   <= '0;
            abort_cnt <= '0;
            stall_cnt <= '0;
        end
        else if (enable)
        begin
            if (pkt_done)
            begin
                captured <= 1'b1;
                pkt_cnt  <= pkt_cnt + 1'b1;
            end
            if (pkt_abort)
                abort_cnt <= abort_cnt + 1'b1;
            if (stall && !stall_q)
                stall_cnt <= stall_cnt + 1'b1;
        end
    end

    always_ff @(posedge iol2clk)
    begin
        if (enable && pkt_done)
        begin
            pkt_q  <= pkt;
            beat_q <= first_beat;
            rec_q  <= recognized;
        end
    end

    // Nothing shows until a packet has been captured since reset or clear
    assign last_pkt = captured ? pkt_q : '0;

    always_comb
    begin
        last_info = '0;
        if (captured)
        begin
            last_info[BEAT_W-1:0]    = beat_q;
            last_info[INFO_REC_BIT]  = rec_q;
            last_info[INFO_CAPT_BIT] = 1'b1;
        end
    end

endmodule

// File: mon_csr_wb.sv
// Wishbone classic slave of the link monitor with the control register and lane read mux
`timescale 1ns/100ps

module mon_csr_wb
    import mcu_link_pkg::*;
    import mon_csr_pkg::*;
#(
    parameter int NUM_LANES = 8
)
(
    input  logic                          iol2clk,
    input  logic                          rst,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [WB_ADR_W-1:0]           wb_adr,
    input  logic [WB_DAT_W-1:0]           wb_dat_w,
    input  logic [NUM_LANES*PKT_W-1:0]    last_pkt,
    input  logic [NUM_LANES*WB_DAT_W-1:0] last_info,
    input  logic [NUM_LANES*CNT_W-1:0]    pkt_cnt,
    input  logic [NUM_LANES*CNT_W-1:0]    abort_cnt,
    input  logic [NUM_LANES*CNT_W-1:0]    stall_cnt,
    output logic [WB_DAT_W-1:0]           wb_dat_r,
    output logic                          wb_ack,
    output logic                          enable,
    output logic                          clear
);

    logic                  bus_req;
    logic                  ctrl_sel;
    logic                  ctrl_wr;
    logic [LANE_SEL_W-1:0] lane_sel;
    logic [REG_SEL_W-1:0]  reg_sel;
    logic [WB_DAT_W-1:0]   rd_data;

    assign lane_sel = wb_adr[WB_ADR_W-1 -: LANE_SEL_W];
    assign reg_sel  = wb_adr[REG_SEL_W-1:0];

    // A new access is one not yet acknowledged, so ack lasts a single cycle
    assign bus_req  = wb_cyc && wb_stb && !wb_ack;
    assign ctrl_sel = (lane_sel == CTRL_LANE) && (reg_sel == REG_CTRL);
    assign ctrl_wr  = bus_req && wb_we && ctrl_sel;

    always_comb
    begin
        rd_data = '0;
        if (lane_sel == CTRL_LANE)
        begin
            if (reg_sel == REG_CTRL)
                rd_data[CTRL_ENABLE_BIT] = enable;
        end
        else if (lane_sel < NUM_LANES)
        begin
            case (reg_sel)
                REG_PKT0, REG_PKT1, REG_PKT2, REG_PKT3:
                    rd_data = last_pkt[lane_sel*PKT_W + reg_sel[1:0]*WB_DAT_W +: WB_DAT_W];
                REG_INFO:
                    rd_data = last_info[lane_sel*WB_DAT_W +: WB_DAT_W];
                REG_PKT_CNT:
                    rd_data[CNT_W-1:0] = pkt_cnt[lane_sel*CNT_W +: CNT_W];
                REG_ABORT_CNT:
                    rd_data[CNT_W-1:0] = abort_cnt[lane_sel*CNT_W +: CNT_W];
                REG_STALL_CNT:
                    rd_data[CNT_W-1:0] = stall_cnt[lane_sel*CNT_W +: CNT_W];
                default:
                    rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge iol2clk)
    begin
        if (rst)
        begin
            wb_ack <= 1'b0;
            enable <= 1'b1;
            clear  <= 1'b0;
        end
        else
        begin
            wb_ack <= bus_req;
            // Clear is a strobe and never reads back as set
            clear  <= ctrl_wr && wb_dat_w[CTRL_CLEAR_BIT];
            if (ctrl_wr)
                enable <= wb_dat_w[CTRL_ENABLE_BIT];
        end
    end

    always_ff @(posedge iol2clk)
    begin
        if (bus_req)
            wb_dat_r <= rd_data;
    end

endmodule

// File: ncu_mcu_link_mon.sv
// Top of the NCU-MCU link monitor: one assembler and stats pair per lane behind a Wishbone CSR
`timescale 1ns/100ps

module ncu_mcu_link_mon
    import mcu_link_pkg::*;
    import mon_csr_pkg::*;
#(
    parameter int NUM_MCU = 4
)
(
    input  logic                      iol2clk,
    input  logic                      rst,
    input  logic [NUM_MCU-1:0]        ncu_mcu_vld,
    input  logic [NUM_MCU*BEAT_W-1:0] ncu_mcu_data,
    input  logic [NUM_MCU-1:0]        mcu_ncu_stall,
    input  logic [NUM_MCU-1:0]        mcu_ncu_vld,
    input  logic [NUM_MCU*BEAT_W-1:0] mcu_ncu_data,
    input  logic [NUM_MCU-1:0]        ncu_mcu_stall,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [WB_ADR_W-1:0]       wb_adr,
    input  logic [WB_DAT_W-1:0]       wb_dat_w,
    output logic [WB_DAT_W-1:0]       wb_dat_r,
    output logic                      wb_ack
);

    localparam int NUM_LANES = 2 * NUM_MCU;

    logic [NUM_LANES-1:0]          lane_vld;
    logic [NUM_LANES-1:0]          lane_stall;
    logic [NUM_LANES*BEAT_W-1:0]   lane_data;
    logic [NUM_LANES-1:0]          pkt_done;
    logic [NUM_LANES-1:0]          pkt_abort;
    logic [NUM_LANES-1:0]          recognized;
    logic [NUM_LANES*PKT_W-1:0]    pkt;
    logic [NUM_LANES*BEAT_W-1:0]   first_beat;
    logic [NUM_LANES*PKT_W-1:0]    last_pkt;
    logic [NUM_LANES*WB_DAT_W-1:0] last_info;
    logic [NUM_LANES*CNT_W-1:0]    pkt_cnt;
    logic [NUM_LANES*CNT_W-1:0]    abort_cnt;
    logic [NUM_LANES*CNT_W-1:0]    stall_cnt;
    logic                          enable;
    logic                          clear;

    // Downstream lanes first, each stalled by the receiving MCU; upstream stalled by the NCU
    assign lane_vld   = {mcu_ncu_vld, ncu_mcu_vld};
    assign lane_data  = {mcu_ncu_data, ncu_mcu_data};
    assign lane_stall = {ncu_mcu_stall, mcu_ncu_stall};

    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        nibble_packet_assembler #(
            .UPSTREAM (i >= NUM_MCU)
        ) u_asm (
            .iol2clk    (iol2clk),
            .rst        (rst),
            .enable     (enable),
            .vld        (lane_vld[i]),
            .stall      (lane_stall[i]),
            .data       (lane_data[i*BEAT_W +: BEAT_W]),
            .pkt_done   (pkt_done[i]),
            .pkt_abort  (pkt_abort[i]),
            .pkt        (pkt[i*PKT_W +: PKT_W]),
            .first_beat (first_beat[i*BEAT_W +: BEAT_W]),
            .recognized (recognized[i])
        );

        lane_stats u_stats (
            .iol2clk    (iol2clk),
            .rst        (rst),
            .enable     (enable),
            .clear      (clear),
            .stall      (lane_stall[i]),
            .pkt_done   (pkt_done[i]),
            .pkt_abort  (pkt_abort[i]),
            .pkt        (pkt[i*PKT_W +: PKT_W]),
            .first_beat (first_beat[i*BEAT_W +: BEAT_W]),
            .recognized (recognized[i]),
            .last_pkt   (last_pkt[i*PKT_W +: PKT_W]),
            .last_info  (last_info[i*WB_DAT_W +: WB_DAT_W]),
            .pkt_cnt    (pkt_cnt[i*CNT_W +: CNT_W]),
            .abort_cnt  (abort_cnt[i*CNT_W +: CNT_W]),
            .stall_cnt  (stall_cnt[i*CNT_W +: CNT_W])
        );
    end

    mon_csr_wb #(
        .NUM_LANES (NUM_LANES)
    ) u_csr (
        .iol2clk   (iol2clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .last_pkt  (last_pkt),
        .last_info (last_info),
        .pkt_cnt   (pkt_cnt),
        .abort_cnt (abort_cnt),
        .stall_cnt (stall_cnt),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .enable    (enable),
        .clear     (clear)
    );

endmodule

// File: tb_ncu_mcu_link_mon.sv
// Random-traffic testbench for the link monitor; run it as the simulation top to check all lane CSRs
`timescale 1ns/100ps

module tb_ncu_mcu_link_mon;

    localparam int NUM_MCU    = 4;
    localparam int NUM_LANES  = 2 * NUM_MCU;
    localparam int MAX_STALL  = 16;
    localparam int MAX_OVER   = 8;
    localparam int MAX_GAP    = 5;
    // Upper bounds on the roughly 94 packets and 700 accesses that the sequence below issues
    localparam int NUM_PKTS   = 100;
    localparam int NUM_ACCESS = 800;
    localparam int CYCLE_LIMIT =
        2 * (NUM_PKTS * (34 + MAX_OVER + MAX_STALL + MAX_GAP) + NUM_ACCESS * 5);
    localparam logic [6:0] CTRL_ADR = 7'h78;

    logic                      clk;
    logic                      rst;
    logic [NUM_MCU-1:0]        ncu_mcu_vld;
    logic [NUM_MCU*4-1:0]      ncu_mcu_data;
    logic [NUM_MCU-1:0]        mcu_ncu_stall;
    logic [NUM_MCU-1:0]        mcu_ncu_vld;
    logic [NUM_MCU*4-1:0]      mcu_ncu_data;
    logic [NUM_MCU-1:0]        ncu_mcu_stall;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [6:0]                wb_adr;
    logic [31:0]               wb_dat_w;
    logic [31:0]               wb_dat_r;
    logic                      wb_ack;

    // Model of what each lane's registers must read
    logic [127:0] m_pkt [NUM_LANES];
    logic [3:0]   m_beat [NUM_LANES];
    logic         m_rec [NUM_LANES];
    logic         m_capt [NUM_LANES];
    logic [15:0]  m_pkt_cnt [NUM_LANES];
    logic [15:0]  m_abort_cnt [NUM_LANES];
    logic [15:0]  m_stall_cnt [NUM_LANES];
    logic         m_prev_stall [NUM_LANES];
    logic         m_enable;
    int           errors;
    int           checks;
    int           cycle_cnt;

    ncu_mcu_link_mon #(
        .NUM_MCU (NUM_MCU)
    ) DUT (
        .iol2clk       (clk),
        .rst           (rst),
        .ncu_mcu_vld   (ncu_mcu_vld),
        .ncu_mcu_data  (ncu_mcu_data),
        .mcu_ncu_stall (mcu_ncu_stall),
        .mcu_ncu_vld   (mcu_ncu_vld),
        .mcu_ncu_data  (mcu_ncu_data),
        .ncu_mcu_stall (ncu_mcu_stall),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Command sets per direction as the link protocol defines them
    function automatic logic code_known(input logic upstream, input logic [3:0] code);
        if (upstream)
            return code inside {4'h0, 4'h1, 4'h3, 4'h7, 4'h8, 4'hc};
        return code inside {4'h4, 4'h5, 4'h6};
    endfunction

    function automatic logic [31:0] expected_reg(input int lane, input int r);
        logic [127:0] p;
        p = m_capt[lane] ? m_pkt[lane] : 128'h0;
        case (r)
            0, 1, 2, 3:
                return p[r*32 +: 32];
            4:
                return m_capt[lane] ? {23'h0, 1'b1, 3'h0, m_rec[lane], m_beat[lane]} : 32'h0;
            5:
                return {16'h0, m_pkt_cnt[lane]};
            6:
                return {16'h0, m_abort_cnt[lane]};
            default:
                return {16'h0, m_stall_cnt[lane]};
        endcase
    endfunction

    // Strobe goes out on one edge, and ack must show after the next edge for one cycle only
    task wb_access(input logic we, input logic [6:0] adr, input logic [31:0] wdat,
                   output logic [31:0] rdat);
        int waited;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!wb_ack && waited < 8);
        rdat = wb_dat_r;
        check_value($sformatf("ack delay at address %h", adr), 32'(waited), 32'd2);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        check_value($sformatf("ack length at address %h", adr), {31'h0, wb_ack}, 32'h0);
    endtask

    task check_lane(input int lane);
        logic [31:0] rd;
        for (int r = 0; r < 8; r++)
        begin
            wb_access(1'b0, {lane[3:0], r[2:0]}, 32'h0, rd);
            check_value($sformatf("lane %0d register %0d", lane, r), rd, expected_reg(lane, r));
        end
    endtask

    task check_all();
        for (int lane = 0; lane < NUM_LANES; lane++)
            check_lane(lane);
    endtask

    task drive_lane(input int lane, input logic v, input logic s, input logic [3:0] d);
        if (lane < NUM_MCU)
        begin
            ncu_mcu_vld[lane]          <= v;
            mcu_ncu_stall[lane]        <= s;
            ncu_mcu_data[lane*4 +: 4]  <= d;
        end
        else
        begin
            mcu_ncu_vld[lane-NUM_MCU]              <= v;
            ncu_mcu_stall[lane-NUM_MCU]            <= s;
            mcu_ncu_data[(lane-NUM_MCU)*4 +: 4]    <= d;
        end
    endtask

    task note_stall(input int lane, input logic s);
        if (s && !m_prev_stall[lane] && m_enable)
            m_stall_cnt[lane] = m_stall_cnt[lane] + 16'd1;
        m_prev_stall[lane] = s;
    endtask

    // Offers a number of unstalled valid beats, then drops valid and updates the model
    task send_packet(input int lane, input int offered, input logic [3:0] code,
                     input int stall_pct);
        logic [127:0] acc;
        logic [3:0]   beat;
        logic         s;
        int           taken;
        int           stalls;
        acc    = '0;
        taken  = 0;
        stalls = 0;
        while (taken < offered)
        begin
            @(posedge clk);
            s    = (stalls < MAX_STALL) && (($urandom % 100) < 32'(stall_pct));
            beat = (taken == 0) ? code : 4'($urandom);
            drive_lane(lane, 1'b1, s, beat);
            note_stall(lane, s);
            if (s)
                stalls++;
            else
            begin
                if (taken < 32)
                    acc[taken*4 +: 4] = beat;
                taken++;
            end
        end
        @(posedge clk);
        drive_lane(lane, 1'b0, 1'b0, 4'h0);
        note_stall(lane, 1'b0);
        if (m_enable && offered >= 32)
        begin
            m_pkt[lane]     = acc;
            m_beat[lane]    = code;
            m_rec[lane]     = code_known(lane >= NUM_MCU, code);
            m_capt[lane]    = 1'b1;
            m_pkt_cnt[lane] = m_pkt_cnt[lane] + 16'd1;
        end
        else if (m_enable)
            m_abort_cnt[lane] = m_abort_cnt[lane] + 16'd1;
        repeat (2 + $urandom % (MAX_GAP - 1)) @(posedge clk);
    endtask

    task clear_model();
        for (int lane = 0; lane < NUM_LANES; lane++)
        begin
            m_capt[lane]      = 1'b0;
            m_pkt_cnt[lane]   = 16'h0;
            m_abort_cnt[lane] = 16'h0;
            m_stall_cnt[lane] = 16'h0;
        end
    endtask

    initial
    begin
        logic [31:0] rd;
        logic [3:0]  code_base;
        clk           = 1'b0;
        rst           = 1'b1;
        ncu_mcu_vld   = '0;
        ncu_mcu_data  = '0;
        mcu_ncu_stall = '0;
        mcu_ncu_vld   = '0;
        mcu_ncu_data  = '0;
        ncu_mcu_stall = '0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        errors        = 0;
        checks        = 0;
        cycle_cnt     = 0;
        m_enable      = 1'b1;
        clear_model();
        for (int lane = 0; lane < NUM_LANES; lane++)
        begin
            m_prev_stall[lane] = 1'b0;
            m_pkt[lane]        = '0;
        end
        void'($urandom(32'h75583878));
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        check_all();
        wb_access(1'b0, CTRL_ADR, 32'h0, rd);
        check_value("control after reset", rd, 32'h1);
        wb_access(1'b0, {4'd9, 3'd5}, 32'h0, rd);
        check_value("unmapped lane", rd, 32'h0);

        // Mostly known commands on the downstream lanes
        for (int lane = 0; lane < NUM_MCU; lane++)
            for (int k = 0; k < 3; k++)
                send_packet(lane, 32, (k < 2) ? 4'(4 + $urandom % 3) : 4'($urandom), 0);
        check_all();

        // Every upstream code appears once, starting from a random one
        code_base = 4'($urandom);
        for (int lane = NUM_MCU; lane < NUM_LANES; lane++)
            for (int k = 0; k < 4; k++)
            begin
                send_packet(lane, 32, code_base + 4'((lane - NUM_MCU) * 4 + k), 0);
                check_lane(lane);
            end
        send_packet(0, 32, 4'h4, 0);
        check_lane(0);
        send_packet(NUM_MCU, 32, 4'h4, 0);
        check_lane(NUM_MCU);

        for (int lane = 0; lane < NUM_LANES; lane++)
            for (int k = 0; k < 3; k++)
                send_packet(lane, 32, 4'($urandom), 30);
        check_all();

        // Short packets abort and long ones keep their first 32 beats
        for (int lane = 0; lane < NUM_LANES; lane++)
        begin
            send_packet(lane, 1 + $urandom % 31, 4'($urandom), 20);
            check_lane(lane);
            send_packet(lane, 33 + $urandom % MAX_OVER, 4'($urandom), 20);
            check_lane(lane);
        end

        wb_access(1'b1, {4'd2, 3'd5}, 32'hffff, rd);
        check_lane(2);

        wb_access(1'b1, CTRL_ADR, 32'h3, rd);
        clear_model();
        check_all();
        wb_access(1'b0, CTRL_ADR, 32'h0, rd);
        check_value("control after clear", rd, 32'h1);

        wb_access(1'b1, CTRL_ADR, 32'h0, rd);
        m_enable = 1'b0;
        wb_access(1'b0, CTRL_ADR, 32'h0, rd);
        check_value("control while disabled", rd, 32'h0);
        for (int lane = 0; lane < NUM_LANES; lane++)
        begin
            send_packet(lane, 32, 4'($urandom), 30);
            send_packet(lane, 1 + $urandom % 31, 4'($urandom), 30);
        end
        check_all();

        wb_access(1'b1, CTRL_ADR, 32'h1, rd);
        m_enable = 1'b1;
        for (int lane = 0; lane < NUM_LANES; lane++)
            send_packet(lane, 32, 4'($urandom), 30);
        check_all();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: ncu_mcu_link_mon.f
mcu_link_pkg.sv
mon_csr_pkg.sv
nibble_packet_assembler.sv
lane_stats.sv
mon_csr_wb.sv
ncu_mcu_link_mon.sv
tb_ncu_mcu_link_mon.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only -Wall
TOP        = tb_ncu_mcu_link_mon
RTL_TOP    = ncu_mcu_link_mon
FILELIST   = ncu_mcu_link_mon.f
OBJ_DIR    = obj_dir
PASS_MSG   = SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
